// ==== Bender.yml ====
package:
  name: forth_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/forth_pkg.sv
      - rtl/code_mem.sv
      - rtl/data_stack.sv
      - rtl/exec_unit.sv
      - rtl/ctrl_regs.sv
      - rtl/forth_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/forth_core_properties.sv
      - dv/forth_core_tb.sv

// ==== dv/forth_core_properties.sv ====
// concurrent checks on the forth core, bound into every forth_core instance
// watches the core ports plus the control and status structs inside it
`timescale 1ns/1ps
`include "forth_config.svh"

module forth_core_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    running,
    input forth_pkg::code_addr_t   ip,
    input forth_pkg::depth_t       depth,
    input logic                    underflow,
    input logic                    overflow,
    input forth_pkg::ctrl_t        ctrl,
    input forth_pkg::core_status_t status
);

    logic step;       // plain instruction cycle, ip moves on
    int   fails = 0;  // failed checks so far

    assign step = running && !ctrl.start && !status.halt
                  && !status.underflow && !status.overflow;

    reset_idle: assert property (@(posedge clk) rst |=> !running)
        else begin
            $error("core is running right after reset");
            fails++;
        end

    ip_steps: assert property (@(posedge clk) disable iff (rst)
        step |=> ip == $past(ip) + 1'b1)   // wraps at the code address width
        else begin
            $error("ip did not advance by one on an instruction cycle");
            fails++;
        end

    depth_bound: assert property (@(posedge clk) disable iff (rst)
        depth <= `FS_DEPTH)
        else begin
            $error("stack depth beyond its capacity");
            fails++;
        end

    // the fault edge also clears run, so both show in the same cycle
    stop_on_fault: assert property (@(posedge clk) disable iff (rst)
        ($rose(underflow) || $rose(overflow)) |-> !running)
        else begin
            $error("core still running after a fault flag set");
            fails++;
        end

endmodule

bind forth_core forth_core_properties u_forth_core_properties (
    .clk, .rst, .running, .ip, .depth, .underflow, .overflow, .ctrl, .status
);

// ==== dv/forth_core_tb.sv ====
// testbench of the forth core: loads short programs, starts the core and
// compares the state it halts in with a queue-based reference model
`timescale 1ns/1ps
`include "forth_config.svh"

module forth_core_tb;
    import forth_pkg::*;

    logic       clk, rst, code_we, reg_we, running, underflow, overflow;
    logic [1:0] reg_addr;
    code_wr_t   code_wr;
    cell_t      reg_wdata, tos;
    code_addr_t ip;
    depth_t     depth;

    integer     seed = 32'hc586_4718;
    logic [7:0] prog[$];                // bytes of the current program
    cell_t      m_stk[$];               // model cells below tos, nos at the back
    cell_t      m_tos;
    code_addr_t m_ip;                   // byte the model stopped on
    logic       m_uf, m_of;             // model sticky flags
    logic       waiting;                // core expected busy
    int         wait_cycles, budget;    // watchdog count and limit
    int         errs, n_pass, n_fail;
    int         prop_seen;              // property failures already counted

    opcode_e alu_ops[10] = '{OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR,
                             OP_MAX, OP_MIN, OP_ABS, OP_INV};
    opcode_e cmp_ops[9]  = '{OP_ZEQ, OP_ZLT, OP_ZGT, OP_EQ, OP_NE,
                             OP_GT, OP_LT, OP_GE, OP_LE};

    forth_core u_forth_core (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // budget grows by program length plus 20 with each run
    always @(posedge clk) begin
        if (waiting) begin
            wait_cycles++;
            if (wait_cycles > budget) begin
                $display("timeout: the core never halted within %0d cycles", budget);
                end_run(1'b0);
            end
        end
    end

    task automatic end_run(input bit ok);
        if (ok) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic write_reg(input logic [1:0] addr, input cell_t data);
        @(negedge clk);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we    = 1'b0;   // one rising edge sees the write
    endtask

    function automatic logic [7:0] rand_lit();
        return 8'h80 | 8'($random(seed));
    endfunction

    // literal, inverted when neg so the operand turns negative
    task automatic push_operand(input logic [7:0] lit, input bit neg);
        prog.push_back(lit);
        if (neg) begin
            prog.push_back(8'(OP_INV));
        end
    endtask

    // word semantics, n is nos and t is tos
    function automatic cell_t ref_result(opcode_e op, cell_t n, cell_t t);
        case (op)
            OP_ADD:  return n + t;
            OP_SUB:  return n - t;
            OP_MUL:  return n * t;
            OP_AND:  return n & t;
            OP_OR:   return n | t;
            OP_XOR:  return n ^ t;
            OP_ABS:  return ($signed(t) < 0) ? -t : t;
            OP_INV:  return ~t;
            OP_MAX:  return ($signed(n) > $signed(t)) ? n : t;
            OP_MIN:  return ($signed(n) < $signed(t)) ? n : t;
            OP_ZEQ:  return cell_t'(t == '0);
            OP_ZLT:  return cell_t'($signed(t) < 0);
            OP_ZGT:  return cell_t'($signed(t) > 0);
            OP_EQ:   return cell_t'(n == t);
            OP_NE:   return cell_t'(n != t);
            OP_GT:   return cell_t'($signed(n) > $signed(t));
            OP_LT:   return cell_t'($signed(n) < $signed(t));
            OP_GE:   return cell_t'($signed(n) >= $signed(t));
            OP_LE:   return cell_t'($signed(n) <= $signed(t));
            default: return t;   // nop and unused codes
        endcase
    endfunction

    // steps the model over prog from a fresh start at base
    task automatic model_run(input code_addr_t base);
        opcode_e op;
        logic    lit, binary, stop;
        cell_t   n;
        m_stk.delete();
        m_tos = '0;
        stop  = 1'b0;
        for (int i = 0; i < prog.size() && !stop; i++) begin
            lit    = prog[i][7];
            op     = opcode_e'(prog[i][6:0]);
            binary = !lit && op inside {[OP_ADD:OP_XOR], OP_MAX, OP_MIN, [OP_EQ:OP_LE]};
            m_ip   = base + code_addr_t'(i);
            if (!lit && op == OP_HALT) begin
                stop = 1'b1;
            end else if (m_stk.size() == 0
                         && (binary || (!lit && op inside {OP_DROP, OP_OVER, OP_SWAP}))) begin
                m_uf = 1'b1;   // faulting word leaves everything as it was
                stop = 1'b1;
            end else if ((lit || op inside {OP_DUP, OP_OVER}) && m_stk.size() == `FS_DEPTH) begin
                m_of = 1'b1;
                stop = 1'b1;
            end else if (lit) begin
                m_stk.push_back(m_tos);
                m_tos = cell_t'(prog[i][6:0]);
            end else begin
                case (op)
                    OP_DUP:  m_stk.push_back(m_tos);
                    OP_DROP: m_tos = m_stk.pop_back();
                    OP_OVER, OP_SWAP: begin
                        n = m_stk.pop_back();
                        if (op == OP_OVER) begin
                            m_stk.push_back(n);
                        end
                        m_stk.push_back(m_tos);
                        m_tos = n;
                    end
                    default: m_tos = binary ? ref_result(op, m_stk.pop_back(), m_tos)
                                            : ref_result(op, '0, m_tos);
                endcase
            end
        end
    endtask

    task automatic check_state(input string tag);
        assert (!running && tos === m_tos && ip === m_ip && underflow === m_uf
                && overflow === m_of && depth === depth_t'(m_stk.size()))
        else begin
            errs++;
            $display("MISMATCH %0t: %s tos %h/%h ip %h/%h depth %0d/%0d uf %b/%b of %b/%b",
                     $time, tag, tos, m_tos, ip, m_ip, depth, m_stk.size(),
                     underflow, m_uf, overflow, m_of);
        end
    endtask

    // load prog at base, start there and wait for running to drop
    task automatic run_program(input code_addr_t base, input string tag);
        foreach (prog[i]) begin
            @(negedge clk);
            code_we = 1'b1;
            code_wr = '{addr: base + code_addr_t'(i), data: prog[i]};
        end
        @(negedge clk);
        code_we = 1'b0;
        model_run(base);
        budget += prog.size() + 20;
        write_reg(2'd1, cell_t'(base));
        write_reg(2'd0, 1);
        waiting = 1'b1;
        while (!running) begin
            @(negedge clk);
        end
        while (running) begin
            @(negedge clk);   // outputs settled half a cycle after the edge
        end
        waiting = 1'b0;
        check_state(tag);
    endtask

    task automatic finish_test(input string name);
        errs += u_forth_core.u_forth_core_properties.fails - prop_seen;
        prop_seen = u_forth_core.u_forth_core_properties.fails;
        if (errs == 0) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, errs);
        end
        errs = 0;
    endtask

    initial begin
        int         d;
        int         k;
        logic [7:0] a8, b8;
        rst       = 1'b1;
        code_we   = 1'b0;
        code_wr   = '0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        {waiting, m_uf, m_of} = '0;
        {wait_cycles, budget, errs, n_pass, n_fail, prop_seen} = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst   = 1'b0;
        m_tos = '0;
        m_ip  = `FS_IP0;
        check_state("reset");
        finish_test("reset state");

        // random stack word mix, kept inside the stack limits
        for (int r = 0; r < 3; r++) begin
            prog.delete();
            d = 0;
            repeat (24) begin
                k = $unsigned($random(seed)) % 5;
                if (d == 0 && k >= 2) begin
                    k = 0;
                end
                if (d == `FS_DEPTH && k != 2 && k != 4) begin
                    k = 2;
                end
                case (k)
                    0:       prog.push_back(rand_lit());
                    1:       prog.push_back(8'(OP_DUP));
                    2:       prog.push_back(8'(OP_DROP));
                    3:       prog.push_back(8'(OP_OVER));
                    default: prog.push_back(8'(OP_SWAP));
                endcase
                d += (k == 2) ? -1 : (k == 4) ? 0 : 1;
            end
            prog.push_back(8'(OP_HALT));
            run_program(code_addr_t'(r * 64), "stack words");
        end
        finish_test("literals and stack words");

        foreach (alu_ops[j]) begin
            repeat (3) begin
                prog.delete();
                push_operand(rand_lit(), 1'($random(seed)));
                push_operand(rand_lit(), 1'($random(seed)));
                prog.push_back(8'(alu_ops[j]));
                prog.push_back(8'(OP_HALT));
                run_program(10'h100, "alu");
            end
        end
        finish_test("arithmetic and bitwise");

        // kinds: equal, ordered, both negative, mixed sign, zero on top
        foreach (cmp_ops[j]) begin
            for (int kind = 0; kind < 5; kind++) begin
                prog.delete();
                a8 = rand_lit();
                b8 = (kind == 0) ? a8 : (kind == 4) ? 8'h80 : rand_lit();
                if (kind == 1 && b8 == a8) begin
                    b8 = a8 ^ 8'h01;
                end
                push_operand(a8, kind == 2 || kind == 3);
                push_operand(b8, kind == 2);
                prog.push_back(8'(cmp_ops[j]));
                prog.push_back(8'(OP_HALT));
                run_program(10'h180, "compare");
            end
        end
        finish_test("comparisons");

        prog.delete();
        prog.push_back(8'(OP_INV));    // nonzero tos over an empty stack
        prog.push_back(8'(OP_DROP));
        prog.push_back(8'(OP_HALT));
        run_program(10'h040, "underflow");
        write_reg(2'd2, 1);
        m_uf = 1'b0;
        check_state("underflow clear");
        finish_test("underflow");

        prog.delete();
        repeat (`FS_DEPTH + 2) prog.push_back(rand_lit());
        prog.push_back(8'(OP_HALT));
        run_program(10'h080, "overflow");
        write_reg(2'd2, 2);
        m_of = 1'b0;
        prog.delete();
        push_operand(rand_lit(), 1'b1);
        push_operand(rand_lit(), 1'b0);
        prog.push_back(8'(OP_ADD));
        prog.push_back(8'(OP_HALT));
        run_program(10'h300, "restart");
        finish_test("overflow and restart");

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        end_run(n_fail == 0);
    end

endmodule

// ==== forth_core.f ====
+incdir+rtl
rtl/forth_pkg.sv
rtl/code_mem.sv
rtl/data_stack.sv
rtl/exec_unit.sv
rtl/ctrl_regs.sv
rtl/forth_core.sv
dv/forth_core_properties.sv
dv/forth_core_tb.sv

// ==== rtl/code_mem.sv ====
// byte-wide program memory of the forth core
// written by the host one byte per strobe, read by the execution unit
// without a clock so fetch and execute share one cycle
`timescale 1ns/1ps
`include "forth_config.svh"

module code_mem (
    input  logic                  clk,
    input  logic                  code_we,
    input  forth_pkg::code_wr_t   code_wr,
    input  forth_pkg::code_addr_t raddr,
    output forth_pkg::code_byte_u rdata
);

    // 2^FS_ASZ program bytes, contents undefined until loaded
    logic [7:0] mem [2**`FS_ASZ];

    // host write port
    always_ff @(posedge clk) begin
        if (code_we) begin
            mem[code_wr.addr] <= code_wr.data;
        end
    end

    // fetch port, byte at ip seen in the same cycle
    assign rdata = mem[raddr];   // same 8 bits, decoded by the union views

endmodule

// ==== rtl/ctrl_regs.sv ====
// run control, start address and sticky fault flags of the forth core
// reg 0 run, reg 1 start address, reg 2 faults (bit 0 under, bit 1 over, w1c)
`timescale 1ns/1ps
`include "forth_config.svh"

module ctrl_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    reg_we,
    input  logic [1:0]              reg_addr,
    input  forth_pkg::cell_t        reg_wdata,
    input  forth_pkg::core_status_t status,
    output forth_pkg::ctrl_t        ctrl,
    output logic                    underflow,
    output logic                    overflow
);
    import forth_pkg::*;

    localparam logic [1:0] REG_RUN   = 2'd0;
    localparam logic [1:0] REG_START = 2'd1;
    localparam logic [1:0] REG_FAULT = 2'd2;

    logic       run_q;
    logic       start_q;
    code_addr_t start_addr_q;
    logic       wr_run;
    logic       wr_start;
    logic       wr_fault;
    logic       stop;       // halt or fault from the execution unit

    assign wr_run   = reg_we && (reg_addr == REG_RUN);
    assign wr_start = reg_we && (reg_addr == REG_START);
    assign wr_fault = reg_we && (reg_addr == REG_FAULT);
    assign stop     = status.halt || status.underflow || status.overflow;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q        <= 1'b0;
            start_q      <= 1'b0;
            start_addr_q <= `FS_IP0;
            underflow    <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            start_q <= wr_run && reg_wdata[0] && !run_q;   // only on 0 to 1
            if (stop) begin
                run_q <= 1'b0;
            end else if (wr_run) begin
                run_q <= reg_wdata[0];
            end
            if (wr_start) begin
                start_addr_q <= reg_wdata[`FS_ASZ-1:0];
            end
            // set beats clear in the same cycle
            if (status.underflow) begin
                underflow <= 1'b1;
            end else if (wr_fault && reg_wdata[0]) begin
                underflow <= 1'b0;
            end
            if (status.overflow) begin
                overflow <= 1'b1;
            end else if (wr_fault && reg_wdata[1]) begin
                overflow <= 1'b0;
            end
        end
    end

    assign ctrl = '{start: start_q, run: run_q, start_addr: start_addr_q};

endmodule

// ==== rtl/data_stack.sv ====
// data stack holding the cells below tos
// the execution unit sends one command per cycle and sees nos, depth,
// empty and full back without delay
`timescale 1ns/1ps
`include "forth_config.svh"

module data_stack (
    input  logic                 clk,
    input  logic                 rst,
    input  forth_pkg::stk_cmd_t  cmd,
    output forth_pkg::stk_view_t view
);
    import forth_pkg::*;

    localparam int PW = $clog2(`FS_DEPTH);   // index width into the array

    cell_t  mem [`FS_DEPTH];
    depth_t sp;      // number of entries, also the next free slot
    depth_t top;     // slot of nos
    logic   empty;
    logic   full;

    assign top   = sp - 1'b1;       // wraps when empty, nos then unused
    assign empty = (sp == '0);
    assign full  = (sp == depth_t'(`FS_DEPTH));

    // cell storage
    always_ff @(posedge clk) begin
        if (cmd.push) begin
            mem[sp[PW-1:0]] <= cmd.wdata;
        end else if (cmd.replace) begin
            mem[top[PW-1:0]] <= cmd.wdata;   // swap puts old tos under the new one
        end
    end

    // pointer, clear wins over any other command
    always_ff @(posedge clk) begin
        if (rst) begin
            sp <= '0;
        end else if (cmd.clear) begin
            sp <= '0;
        end else if (cmd.push) begin
            sp <= sp + 1'b1;
        end else if (cmd.pop) begin
            sp <= sp - 1'b1;
        end
    end

    // view back to the execution unit
    always_comb begin
        view       = '0;
        view.nos   = mem[top[PW-1:0]];
        view.depth = sp;
        view.empty = empty;    // pop or replace here is an underflow
        view.full  = full;     // push here is an overflow
    end

endmodule

// ==== rtl/exec_unit.sv ====
// execution unit: instruction pointer, tos register, decode, alu and compares
// runs one code byte per running cycle, the byte arrives from code_mem at ip
`timescale 1ns/1ps
`include "forth_config.svh"

module exec_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  forth_pkg::ctrl_t        ctrl,
    input  forth_pkg::code_byte_u   instr,
    input  forth_pkg::stk_view_t    stk,
    output forth_pkg::code_addr_t   ip,
    output forth_pkg::stk_cmd_t     stk_cmd,
    output forth_pkg::core_status_t status
);
    import forth_pkg::*;

    code_addr_t ip_q;
    cell_t      tos_q;
    cell_t      tos_n;      // tos after this instruction
    cell_t      alu_res;    // alu group result
    logic       cmp_res;    // compare group result, widened to 0 or 1
    logic       need_nos;   // instruction reads nos
    logic       do_push;
    logic       do_pop;
    logic       do_repl;
    logic       op_halt;
    logic       active;     // a normal running cycle
    logic       uflow;
    logic       oflow;
    logic       exec_ok;    // commit tos, ip and stack update

    // alu group, binary words take nos as left operand
    always_comb begin
        case (instr.op.opcode)
            OP_ADD:  alu_res = stk.nos + tos_q;
            OP_SUB:  alu_res = stk.nos - tos_q;
            OP_MUL:  alu_res = stk.nos * tos_q;      // low cell of product
            OP_AND:  alu_res = stk.nos & tos_q;
            OP_OR:   alu_res = stk.nos | tos_q;
            OP_XOR:  alu_res = stk.nos ^ tos_q;
            OP_ABS:  alu_res = ($signed(tos_q) < 0) ? -tos_q : tos_q;
            OP_INV:  alu_res = ~tos_q;               // bitwise, not a negate
            OP_MAX:  alu_res = ($signed(stk.nos) > $signed(tos_q)) ? stk.nos : tos_q;
            OP_MIN:  alu_res = ($signed(stk.nos) < $signed(tos_q)) ? stk.nos : tos_q;
            default: alu_res = tos_q;
        endcase
    end

    // compare group, all ordered compares signed
    always_comb begin
        case (instr.op.opcode)
            OP_ZEQ:  cmp_res = (tos_q == '0);
            OP_ZLT:  cmp_res = ($signed(tos_q) < 0);
            OP_ZGT:  cmp_res = ($signed(tos_q) > 0);
            OP_EQ:   cmp_res = (stk.nos == tos_q);
            OP_NE:   cmp_res = (stk.nos != tos_q);
            OP_GT:   cmp_res = ($signed(stk.nos) >  $signed(tos_q));
            OP_LT:   cmp_res = ($signed(stk.nos) <  $signed(tos_q));
            OP_GE:   cmp_res = ($signed(stk.nos) >= $signed(tos_q));
            OP_LE:   cmp_res = ($signed(stk.nos) <= $signed(tos_q));
            default: cmp_res = 1'b0;
        endcase
    end

    // dispatcher, literal flag first, then the opcode groups
    always_comb begin
        tos_n    = tos_q;
        need_nos = 1'b0;
        do_push  = 1'b0;
        do_pop   = 1'b0;
        do_repl  = 1'b0;
        op_halt  = 1'b0;
        if (instr.lit.is_lit) begin
            do_push = 1'b1;                          // old tos goes below
            tos_n   = cell_t'(instr.lit.value);
        end else begin
            case (instr.op.opcode)
                OP_HALT: op_halt = 1'b1;
                // stack group
                OP_DUP:  do_push = 1'b1;
                OP_DROP: begin
                    need_nos = 1'b1;
                    do_pop   = 1'b1;
                    tos_n    = stk.nos;
                end
                OP_OVER: begin
                    need_nos = 1'b1;
                    do_push  = 1'b1;
                    tos_n    = stk.nos;
                end
                OP_SWAP: begin
                    need_nos = 1'b1;
                    do_repl  = 1'b1;                 // nos takes old tos
                    tos_n    = stk.nos;
                end
                // alu group
                OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_MAX, OP_MIN: begin
                    need_nos = 1'b1;
                    do_pop   = 1'b1;
                    tos_n    = alu_res;
                end
                OP_ABS, OP_INV: tos_n = alu_res;
                // compare group
                OP_ZEQ, OP_ZLT, OP_ZGT: tos_n = cell_t'(cmp_res);
                OP_EQ, OP_NE, OP_GT, OP_LT, OP_GE, OP_LE: begin
                    need_nos = 1'b1;
                    do_pop   = 1'b1;
                    tos_n    = cell_t'(cmp_res);
                end
                default: tos_n = tos_q;              // nop and unused codes
            endcase
        end
    end

    // faults block the whole update of the faulting instruction
    assign active  = ctrl.run && !ctrl.start;
    assign uflow   = active && need_nos && stk.empty;
    assign oflow   = active && do_push && stk.full;
    assign exec_ok = active && !op_halt && !uflow && !oflow;

    always_comb begin
        stk_cmd         = '0;
        stk_cmd.clear   = ctrl.start;
        stk_cmd.push    = exec_ok && do_push;
        stk_cmd.pop     = exec_ok && do_pop;
        stk_cmd.replace = exec_ok && do_repl;
        stk_cmd.wdata   = tos_q;                     // push and swap both write old tos
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ip_q  <= `FS_IP0;
            tos_q <= '0;
        end else if (ctrl.start) begin
            ip_q  <= ctrl.start_addr;
            tos_q <= '0;
        end else if (exec_ok) begin
            ip_q  <= ip_q + 1'b1;                    // halt keeps ip on the halt byte
            tos_q <= tos_n;
        end
    end

    assign ip     = ip_q;
    assign status = '{ip: ip_q, tos: tos_q, halt: active && op_halt,
                      underflow: uflow, overflow: oflow};

endmodule

// ==== rtl/forth_config.svh ====
// size and reset configuration of the forth core
// include wherever a width, the stack depth or the reset ip is needed
`ifndef FORTH_CONFIG_SVH
`define FORTH_CONFIG_SVH

// data cell width, also the width of tos
`define FS_DSZ 32

// code address width, 1k bytes of program
`define FS_ASZ 10

// data stack entries held below tos
`define FS_DEPTH 16

// ip after reset
`define FS_IP0 0

`endif

// ==== rtl/forth_core.sv ====
// top of the forth core: program memory, data stack, execution unit, registers
// host loads code through code_we, starts the core through reg 0
`timescale 1ns/1ps

module forth_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  code_we,
    input  forth_pkg::code_wr_t   code_wr,
    input  logic                  reg_we,
    input  logic [1:0]            reg_addr,
    input  forth_pkg::cell_t      reg_wdata,
    output logic                  running,
    output forth_pkg::cell_t      tos,
    output forth_pkg::code_addr_t ip,
    output forth_pkg::depth_t     depth,
    output logic                  underflow,
    output logic                  overflow
);
    import forth_pkg::*;

    code_byte_u   instr;      // byte at ip
    stk_cmd_t     stk_cmd;
    stk_view_t    stk_view;
    ctrl_t        ctrl;
    core_status_t status;

    code_mem u_code_mem (
        .clk, .code_we, .code_wr, .raddr(ip), .rdata(instr)
    );

    data_stack u_data_stack (
        .clk, .rst, .cmd(stk_cmd), .view(stk_view)
    );

    exec_unit u_exec_unit (
        .clk, .rst, .ctrl, .instr, .stk(stk_view), .ip, .stk_cmd, .status
    );

    ctrl_regs u_ctrl_regs (
        .clk, .rst, .reg_we, .reg_addr, .reg_wdata, .status, .ctrl,
        .underflow, .overflow
    );

    assign running = ctrl.run;
    assign tos     = status.tos;
    assign depth   = stk_view.depth;

endmodule

// ==== rtl/forth_pkg.sv ====
// shared types of the forth core: cells, opcodes, code byte views and the
// structs that travel between memory, stack, execution unit and registers
`include "forth_config.svh"

package forth_pkg;

    typedef logic [`FS_DSZ-1:0]              cell_t;
    typedef logic [`FS_ASZ-1:0]              code_addr_t;
    typedef logic [$clog2(`FS_DEPTH+1)-1:0]  depth_t;   // 0 up to FS_DEPTH

    // 7-bit opcodes, only reached when bit 7 of the code byte is clear
    typedef enum logic [6:0] {
        OP_NOP  = 7'd0,  OP_HALT = 7'd1,
        OP_DUP  = 7'd2,  OP_DROP = 7'd3,  OP_OVER = 7'd4,  OP_SWAP = 7'd5,
        OP_ADD  = 7'd6,  OP_SUB  = 7'd7,  OP_MUL  = 7'd8,
        OP_AND  = 7'd9,  OP_OR   = 7'd10, OP_XOR  = 7'd11,
        OP_ABS  = 7'd12, OP_INV  = 7'd13, OP_MAX  = 7'd14, OP_MIN  = 7'd15,
        OP_ZEQ  = 7'd16, OP_ZLT  = 7'd17, OP_ZGT  = 7'd18,
        OP_EQ   = 7'd19, OP_NE   = 7'd20, OP_GT   = 7'd21,
        OP_LT   = 7'd22, OP_GE   = 7'd23, OP_LE   = 7'd24
    } opcode_e;

    typedef struct packed {
        logic       is_lit;  // 0 in this view
        opcode_e    opcode;
    } op_view_t;

    typedef struct packed {
        logic       is_lit;  // 1 in this view
        logic [6:0] value;   // zero-extended on push
    } lit_view_t;

    // one code byte, read as opcode or as short literal
    typedef union packed {
        op_view_t   op;
        lit_view_t  lit;
    } code_byte_u;

    typedef struct packed {
        code_addr_t addr;
        logic [7:0] data;
    } code_wr_t;

    typedef struct packed {
        logic       push;     // store wdata above nos
        logic       pop;      // drop nos
        logic       replace;  // overwrite nos with wdata
        logic       clear;    // empty the stack
        cell_t      wdata;
    } stk_cmd_t;

    typedef struct packed {
        cell_t      nos;
        depth_t     depth;
        logic       empty;
        logic       full;
    } stk_view_t;

    typedef struct packed {
        logic       start;       // one cycle, loads ip and clears state
        logic       run;
        code_addr_t start_addr;
    } ctrl_t;

    typedef struct packed {
        code_addr_t ip;
        cell_t      tos;
        logic       halt;        // pulses, one cycle each
        logic       underflow;
        logic       overflow;
    } core_status_t;

endpackage
